// File: hw/mod_cfg.svh
`ifndef MOD_CFG_SVH
`define MOD_CFG_SVH

// intensity samples in one frame, one per transducer.
`define MOD_DEPTH 249

// modulation index width, so each segment holds 2**15 samples.
`define MOD_ADDR_W 15

// number of modulation segments the host can load.
`define MOD_SEGMENTS 2

`endif

// File: hw/mod_pkg.sv
`default_nettype none

`include "mod_cfg.svh"

package mod_pkg;

  typedef logic [7:0] intensity_t;
  typedef logic [7:0] mod_value_t;
  typedef logic [15:0] product_t;
  typedef logic [`MOD_ADDR_W-1:0] mod_idx_t;
  typedef logic [$clog2(`MOD_DEPTH + 3)-1:0] frame_cnt_t;  // frame plus the two load cycles.

  typedef enum logic [1:0] {
    IDLE,
    LOAD_0,
    LOAD_1,
    RUN
  } mult_state_t;

endpackage

`default_nettype wire

// File: hw/mod_stream_if.sv
`default_nettype none

interface mod_stream_if;

  logic               valid;
  mod_pkg::product_t  product;
  logic               last;     // set on the final product of a frame.
  logic               segment;

  // no ready signal, the sink takes every valid cycle.
  modport source (output valid, output product, output last, output segment);

  modport sink (input valid, input product, input last, input segment);

endinterface

`default_nettype wire

// File: hw/mod_memory.sv
`default_nettype none

`include "mod_cfg.svh"

module mod_memory
  import mod_pkg::*;
(
  input  wire              CLK,
  input  wire              wr_en,
  input  wire              wr_segment,
  input  wire mod_idx_t    wr_addr,
  input  wire mod_value_t  wr_data,
  input  wire              rd_segment,
  input  wire mod_idx_t    rd_idx,
  output mod_value_t       rd_value
);

  mod_value_t mem [`MOD_SEGMENTS][2**`MOD_ADDR_W];

  logic     rd_segment_q;
  mod_idx_t rd_idx_q;

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_segment][wr_addr] <= wr_data;
    end
  end

  // address stage then data stage, two cycles from address to value.
  always_ff @(posedge CLK) begin
    rd_segment_q <= rd_segment;
    rd_idx_q     <= rd_idx;
    rd_value     <= mem[rd_segment_q][rd_idx_q];
  end

endmodule

`default_nettype wire

// File: hw/mod_index_timer.sv
`default_nettype none

`include "mod_cfg.svh"

module mod_index_timer
  import mod_pkg::*;
(
  input  wire            CLK,
  input  wire            arst_n,
  input  wire            mod_tick,
  input  wire mod_idx_t  cycle_0,
  input  wire mod_idx_t  cycle_1,
  output mod_idx_t       seg_idx [`MOD_SEGMENTS]
);

  mod_idx_t cycle_val [`MOD_SEGMENTS];

  assign cycle_val[0] = cycle_0;  // last valid index of segment 0.
  assign cycle_val[1] = cycle_1;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < `MOD_SEGMENTS; s++) begin
        seg_idx[s] <= '0;
      end
    end else if (mod_tick) begin
      for (int s = 0; s < `MOD_SEGMENTS; s++) begin
        // a lowered cycle value also wraps the index on the next tick.
        seg_idx[s] <= (seg_idx[s] >= cycle_val[s]) ? '0 : seg_idx[s] + 1'b1;
      end
    end
  end

  for (genvar s = 0; s < `MOD_SEGMENTS; s++) begin : g_idx_chk
    a_idx_in_cycle: assert property (
      @(posedge CLK) disable iff (!arst_n)
      seg_idx[s] <= cycle_val[s]
    );
  end

endmodule

`default_nettype wire

// File: hw/delay_line.sv
`default_nettype none

module delay_line #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 3
) (
  input  wire              CLK,
  input  wire [WIDTH-1:0]  din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] stage [DEPTH];

  always_ff @(posedge CLK) begin
    stage[0] <= din;
    for (int i = 1; i < DEPTH; i++) begin
      stage[i] <= stage[i-1];
    end
  end

  assign dout = stage[DEPTH-1];  // din shows up here DEPTH cycles later.

endmodule

`default_nettype wire

// File: hw/mult_8x8.sv
`default_nettype none

module mult_8x8
  import mod_pkg::*;
(
  input  wire        CLK,
  input  wire [7:0]  a,
  input  wire [7:0]  b,
  output product_t   p
);

  logic [7:0] a_q;
  logic [7:0] b_q;

  always_ff @(posedge CLK) begin
    a_q <= a;
    b_q <= b;
    p   <= a_q * b_q;  // full 16-bit unsigned product.
  end

endmodule

`default_nettype wire

// File: hw/modulation_multiplier.sv
`default_nettype none

`include "mod_cfg.svh"

module modulation_multiplier
  import mod_pkg::*;
(
  input  wire              CLK,
  input  wire              arst_n,
  input  wire              din_valid,
  input  wire intensity_t  intensity_in,
  input  wire              segment,
  input  wire              stop,
  input  wire mod_idx_t    seg_idx [`MOD_SEGMENTS],
  output mod_idx_t         rd_idx,
  output logic             rd_segment,
  input  wire mod_value_t  rd_value,
  mod_stream_if.source     stream
);

  localparam int PIPE_LEN = 5;  // delay line plus multiplier latency.

  mult_state_t state;
  frame_cnt_t  cnt;
  mod_idx_t    idx_q;
  logic        seg_q;
  intensity_t  intensity_dly;
  logic        frame_active;
  logic        frame_last;

  logic [PIPE_LEN-1:0] valid_pipe;
  logic [PIPE_LEN-1:0] last_pipe;
  logic [PIPE_LEN-1:0] seg_pipe;

  assign rd_idx     = idx_q;
  assign rd_segment = seg_q;

  // the two load states already see intensity samples 0 and 1.
  assign frame_active = (state != IDLE);
  assign frame_last   = frame_active && (cnt == `MOD_DEPTH - 1);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      cnt   <= '0;
      idx_q <= '0;
      seg_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (din_valid) begin
            cnt   <= '0;
            state <= LOAD_0;
            if (!stop) begin  // stop keeps the previous frame's index and segment.
              idx_q <= seg_idx[segment];
              seg_q <= segment;
            end
          end
        end
        LOAD_0: begin
          cnt   <= cnt + 1'b1;
          state <= LOAD_1;
        end
        LOAD_1: begin
          cnt   <= cnt + 1'b1;
          state <= RUN;
        end
        RUN: begin
          cnt <= cnt + 1'b1;
          if (frame_last) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  delay_line #(
    .WIDTH($bits(intensity_t)),
    .DEPTH(3)
  ) i_intensity_dly (
    .CLK (CLK),
    .din (intensity_in),
    .dout(intensity_dly)
  );

  mult_8x8 i_mult (
    .CLK(CLK),
    .a  (intensity_dly),
    .b  (rd_value),
    .p  (stream.product)
  );

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      valid_pipe <= '0;
      last_pipe  <= '0;
    end else begin
      valid_pipe <= {valid_pipe[PIPE_LEN-2:0], frame_active};
      last_pipe  <= {last_pipe[PIPE_LEN-2:0], frame_last};
    end
  end

  always_ff @(posedge CLK) begin
    seg_pipe <= {seg_pipe[PIPE_LEN-2:0], seg_q};
  end

  assign stream.valid   = valid_pipe[PIPE_LEN-1];
  assign stream.last    = last_pipe[PIPE_LEN-1];
  assign stream.segment = seg_pipe[PIPE_LEN-1];

  a_valid_run: assert property (
    @(posedge CLK) disable iff (!arst_n)
    $rose(stream.valid) |-> ##[1:`MOD_DEPTH] !stream.valid
  );

endmodule

`default_nettype wire

// File: hw/intensity_limiter.sv
`default_nettype none

module intensity_limiter
  import mod_pkg::*;
(
  input  wire              CLK,
  input  wire              arst_n,
  mod_stream_if.sink       stream,
  input  wire intensity_t  max_intensity,
  output intensity_t       intensity_out,
  output logic             dout_valid,
  output logic             dout_last,
  output logic             dout_segment
);

  intensity_t upper;

  assign upper = stream.product[$bits(product_t)-1 -: $bits(intensity_t)];  // scale back to 8 bits.

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      dout_valid <= 1'b0;
      dout_last  <= 1'b0;
    end else begin
      dout_valid <= stream.valid;
      dout_last  <= stream.valid && stream.last;
    end
  end

  always_ff @(posedge CLK) begin
    intensity_out <= (upper > max_intensity) ? max_intensity : upper;
    dout_segment  <= stream.segment;
  end

  a_limit: assert property (
    @(posedge CLK) disable iff (!arst_n)
    dout_valid |-> intensity_out <= max_intensity
  );

endmodule

`default_nettype wire

// File: hw/modulation_top.sv
`default_nettype none

`include "mod_cfg.svh"

module modulation_top
  import mod_pkg::*;
(
  input  wire              CLK,
  input  wire              arst_n,
  input  wire              din_valid,
  input  wire intensity_t  intensity_in,
  input  wire              segment,
  input  wire              stop,
  input  wire              mod_tick,
  input  wire mod_idx_t    cycle_0,
  input  wire mod_idx_t    cycle_1,
  input  wire intensity_t  max_intensity,
  input  wire              mod_wr_en,
  input  wire              mod_wr_segment,
  input  wire mod_idx_t    mod_wr_addr,
  input  wire mod_value_t  mod_wr_data,
  output intensity_t       intensity_out,
  output logic             dout_valid,
  output logic             dout_last,
  output logic             dout_segment
);

  mod_idx_t   seg_idx [`MOD_SEGMENTS];
  mod_idx_t   rd_idx;
  logic       rd_segment;
  mod_value_t rd_value;

  mod_stream_if product_stream ();

  mod_index_timer i_timer (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .mod_tick(mod_tick),
    .cycle_0 (cycle_0),
    .cycle_1 (cycle_1),
    .seg_idx (seg_idx)
  );

  mod_memory i_memory (
    .CLK       (CLK),
    .wr_en     (mod_wr_en),
    .wr_segment(mod_wr_segment),
    .wr_addr   (mod_wr_addr),
    .wr_data   (mod_wr_data),
    .rd_segment(rd_segment),
    .rd_idx    (rd_idx),
    .rd_value  (rd_value)
  );

  modulation_multiplier i_mult (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .din_valid   (din_valid),
    .intensity_in(intensity_in),
    .segment     (segment),
    .stop        (stop),
    .seg_idx     (seg_idx),
    .rd_idx      (rd_idx),
    .rd_segment  (rd_segment),
    .rd_value    (rd_value),
    .stream      (product_stream.source)
  );

  intensity_limiter i_limiter (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .stream       (product_stream.sink),
    .max_intensity(max_intensity),
    .intensity_out(intensity_out),
    .dout_valid   (dout_valid),
    .dout_last    (dout_last),
    .dout_segment (dout_segment)
  );

endmodule

`default_nettype wire

// File: verif/modulation_top_tb.sv
`default_nettype none

`include "mod_cfg.svh"

module modulation_top_tb
  import mod_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic       seg;
    logic       stop;
    logic [7:0] ticks;
    intensity_t max;
    mod_idx_t   cyc0;
    mod_idx_t   cyc1;
    logic       b2b;       // start as soon as the previous frame goes idle.
    logic       spurious;  // extra din_valid while the frame is running.
  } frame_row_t;

  typedef struct {
    intensity_t value;
    logic       seg;
    logic       last;
    int         due;
  } exp_sample_t;

  localparam int num_rows = 10;
  localparam int num_addr = 16;  // written per segment, above every cycle value in the table.

  // seg, stop, ticks, max, cycle_0, cycle_1, b2b, spurious.
  localparam frame_row_t frame_table [num_rows] = '{
    '{1'b0, 1'b0, 8'd0, 8'd255, 15'd5, 15'd9,  1'b0, 1'b0},
    '{1'b1, 1'b0, 8'd3, 8'd255, 15'd5, 15'd9,  1'b0, 1'b1},
    '{1'b0, 1'b0, 8'd0, 8'd255, 15'd5, 15'd9,  1'b1, 1'b0},
    '{1'b1, 1'b1, 8'd4, 8'd60,  15'd5, 15'd9,  1'b0, 1'b0},
    '{1'b0, 1'b0, 8'd4, 8'd60,  15'd5, 15'd9,  1'b0, 1'b0},
    '{1'b1, 1'b0, 8'd2, 8'd20,  15'd5, 15'd9,  1'b0, 1'b1},
    '{1'b0, 1'b1, 8'd0, 8'd20,  15'd5, 15'd9,  1'b1, 1'b0},
    '{1'b0, 1'b0, 8'd7, 8'd255, 15'd3, 15'd12, 1'b0, 1'b0},
    '{1'b1, 1'b0, 8'd5, 8'd128, 15'd3, 15'd12, 1'b0, 1'b0},
    '{1'b1, 1'b0, 8'd0, 8'd128, 15'd3, 15'd12, 1'b1, 1'b1}
  };

  logic       CLK = 1'b0;
  logic       arst_n;
  logic       din_valid;
  intensity_t intensity_in;
  logic       segment;
  logic       stop;
  logic       mod_tick;
  mod_idx_t   cycle_0;
  mod_idx_t   cycle_1;
  intensity_t max_intensity;
  logic       mod_wr_en;
  logic       mod_wr_segment;
  mod_idx_t   mod_wr_addr;
  mod_value_t mod_wr_data;
  intensity_t intensity_out;
  logic       dout_valid;
  logic       dout_last;
  logic       dout_segment;

  mod_idx_t    model_idx [`MOD_SEGMENTS];
  mod_value_t  mem_copy [`MOD_SEGMENTS][num_addr];
  logic        cur_seg;
  mod_idx_t    cur_idx;
  logic [31:0] rng_state = 32'd85526;
  exp_sample_t exp_q [$];
  int          cyc = 0;
  int          errors = 0;

  modulation_top i_dut (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .din_valid     (din_valid),
    .intensity_in  (intensity_in),
    .segment       (segment),
    .stop          (stop),
    .mod_tick      (mod_tick),
    .cycle_0       (cycle_0),
    .cycle_1       (cycle_1),
    .max_intensity (max_intensity),
    .mod_wr_en     (mod_wr_en),
    .mod_wr_segment(mod_wr_segment),
    .mod_wr_addr   (mod_wr_addr),
    .mod_wr_data   (mod_wr_data),
    .intensity_out (intensity_out),
    .dout_valid    (dout_valid),
    .dout_last     (dout_last),
    .dout_segment  (dout_segment)
  );

  always #4 CLK = ~CLK;

  always @(posedge CLK) cyc <= cyc + 1;  // cycle number used for the latency check.

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] next_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[15:8];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("FAIL %0d ns %s: expected %0h, got %0h", $time, name, expected, actual);
  endtask

  task automatic load_memory();
    for (int s = 0; s < `MOD_SEGMENTS; s++) begin
      for (int a = 0; a < num_addr; a++) begin
        @(negedge CLK);
        mod_wr_en      = 1'b1;
        mod_wr_segment = s[0];
        mod_wr_addr    = mod_idx_t'(a);
        mod_wr_data    = next_byte();
        mem_copy[s][a] = mod_wr_data;
      end
    end
    @(negedge CLK);
    mod_wr_en = 1'b0;
  endtask

  task automatic issue_ticks(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge CLK);
      mod_tick     = 1'b1;
      model_idx[0] = (model_idx[0] >= cycle_0) ? '0 : model_idx[0] + 1'b1;  // wrap after cycle.
      model_idx[1] = (model_idx[1] >= cycle_1) ? '0 : model_idx[1] + 1'b1;
      @(negedge CLK);
      mod_tick = 1'b0;
    end
  endtask

  task automatic send_frame(input frame_row_t row);
    intensity_t  samples [`MOD_DEPTH];
    mod_value_t  mod_val;
    logic [15:0] prod;
    exp_sample_t e;
    @(negedge CLK);
    din_valid = 1'b1;
    segment   = row.seg;
    stop      = row.stop;
    if (!row.stop) begin
      cur_seg = row.seg;
      cur_idx = model_idx[row.seg];
    end
    mod_val = mem_copy[cur_seg][cur_idx];
    for (int k = 0; k < `MOD_DEPTH; k++) begin
      samples[k] = next_byte();
      prod       = samples[k] * mod_val;
      e.value    = (prod[15:8] > max_intensity) ? max_intensity : prod[15:8];
      e.seg      = cur_seg;
      e.last     = (k == `MOD_DEPTH - 1);
      e.due      = cyc + 7 + k;  // six cycles of latency after sample k in cycle 1+k.
      exp_q.push_back(e);
    end
    for (int k = 0; k < `MOD_DEPTH; k++) begin
      @(negedge CLK);
      din_valid    = row.spurious && (k == 100);
      segment      = ~row.seg;  // the DUT must ignore this while busy.
      stop         = 1'b0;
      intensity_in = samples[k];
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge CLK);
    end
  endtask

  always @(negedge CLK) begin
    exp_sample_t e;
    if (!arst_n) begin
      if (dout_valid !== 1'b0) report_mismatch("dout_valid", 0, dout_valid);
      if (dout_last !== 1'b0) report_mismatch("dout_last", 0, dout_last);
    end else if (dout_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR %0d ns: output sample seen while none was expected", $time);
      end else begin
        e = exp_q.pop_front();
        if (cyc != e.due) report_mismatch("dout_valid cycle", e.due, cyc);
        if (intensity_out !== e.value) report_mismatch("intensity_out", e.value, intensity_out);
        if (dout_segment !== e.seg) report_mismatch("dout_segment", e.seg, dout_segment);
        if (dout_last !== e.last) report_mismatch("dout_last", e.last, dout_last);
      end
    end else begin
      if (dout_valid !== 1'b0) report_mismatch("dout_valid", 0, dout_valid);
      if (dout_last !== 1'b0) report_mismatch("dout_last", 0, dout_last);
      if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
        errors++;
        $display("ERROR %0d ns: expected output sample did not appear", $time);
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin
    int limit;
    limit = 100 + `MOD_SEGMENTS * num_addr;
    for (int r = 0; r < num_rows; r++) begin
      limit += `MOD_DEPTH + 40 + frame_table[r].ticks;
    end
    repeat (limit) @(posedge CLK);
    errors++;
    $display("Timeout: the run did not finish within %0d clock cycles.", limit);
    $display("Errors: %0d", errors);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    arst_n         = 1'b0;
    din_valid      = 1'b0;
    intensity_in   = '0;
    segment        = 1'b0;
    stop           = 1'b0;
    mod_tick       = 1'b0;
    cycle_0        = '0;
    cycle_1        = '0;
    max_intensity  = 8'd255;
    mod_wr_en      = 1'b0;
    mod_wr_segment = 1'b0;
    mod_wr_addr    = '0;
    mod_wr_data    = '0;
    model_idx[0]   = '0;
    model_idx[1]   = '0;
    cur_seg        = 1'b0;
    cur_idx        = '0;
    repeat (4) @(negedge CLK);
    arst_n = 1'b1;
    load_memory();
    for (int r = 0; r < num_rows; r++) begin
      if (!frame_table[r].b2b) begin
        wait_drain();
        @(negedge CLK);
        max_intensity = frame_table[r].max;
        cycle_0       = frame_table[r].cyc0;
        cycle_1       = frame_table[r].cyc1;
        issue_ticks(frame_table[r].ticks);
      end
      send_frame(frame_table[r]);
    end
    wait_drain();
    repeat (20) @(negedge CLK);  // a frame started by an ignored strobe would show up here.
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hw
hw/mod_pkg.sv
hw/mod_stream_if.sv
hw/mod_memory.sv
hw/mod_index_timer.sv
hw/delay_line.sv
hw/mult_8x8.sv
hw/modulation_multiplier.sv
hw/intensity_limiter.sv
hw/modulation_top.sv
verif/modulation_top_tb.sv
